/* common/float_mul_settings.svh */
`ifndef FLOAT_MUL_SETTINGS_SVH
`define FLOAT_MUL_SETTINGS_SVH

// binary32 field layout

// exponent field
`define FLOAT_EXP_WIDTH 8

// stored mantissa, hidden bit not counted
`define FLOAT_MANT_WIDTH 23

// sign + exponent + mantissa
`define FLOAT_WIDTH 32

// exponent bias
`define FLOAT_BIAS 127

`endif

/* common/float_pkg.sv */
`include "float_mul_settings.svh"

package float_pkg;

    // ****************************************
    // word format
    // ****************************************

    typedef struct packed {
        logic                         sign;
        logic [`FLOAT_EXP_WIDTH-1:0]  exp;
        logic [`FLOAT_MANT_WIDTH-1:0] mant;
    } float_t;

    // ****************************************
    // operand / result class
    // ****************************************

    typedef enum logic [1:0] {
        FC_ZERO   = 2'd0, // zero exponent, subnormals included
        FC_NORMAL = 2'd1,
        FC_INF    = 2'd2  // all-ones exponent
    } float_class_e;

    // ****************************************
    // pipeline payload types
    // ****************************************

    // two extra bits over the exponent field so that both
    // overflow and a negative (underflowed) sum are visible
    typedef logic signed [`FLOAT_EXP_WIDTH+1:0] exp_sum_t;

    // significand with the hidden one
    typedef logic [`FLOAT_MANT_WIDTH:0] sig_t;

    // full product of two significands
    typedef logic [2*`FLOAT_MANT_WIDTH+1:0] prod_t;

endpackage

/* design/float_unpack_stage.sv */
`timescale 1ns/10ps
`include "float_mul_settings.svh"

module float_unpack_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  float_pkg::float_t       a,
    input  float_pkg::float_t       b,
    output logic                    s1_valid,
    output logic                    s1_sign,
    output float_pkg::float_class_e s1_class,
    output float_pkg::exp_sum_t     s1_exp,
    output float_pkg::sig_t         s1_sig_a,
    output float_pkg::sig_t         s1_sig_b
);
    import float_pkg::*;

    float_class_e class_a;
    float_class_e class_b;
    float_class_e class_ab;
    exp_sum_t     exp_sum;

    function automatic float_class_e classify(input float_t f);
        float_class_e c;
        if (f.exp == '0) begin
            c = FC_ZERO; // subnormals read as zero
        end else if (&f.exp) begin
            c = FC_INF; // NaN encodings read as infinity too
        end else begin
            c = FC_NORMAL;
        end
        return c;
    endfunction

    // ****************************************
    // classify and add exponents
    // ****************************************

    always_comb begin
        class_a = classify(a);
        class_b = classify(b);

        if (class_a == FC_ZERO || class_b == FC_ZERO) begin
            class_ab = FC_ZERO; // zero wins over infinity
        end else if (class_a == FC_INF || class_b == FC_INF) begin
            class_ab = FC_INF;
        end else begin
            class_ab = FC_NORMAL;
        end

        exp_sum = exp_sum_t'({2'b00, a.exp})
                + exp_sum_t'({2'b00, b.exp})
                - exp_sum_t'(`FLOAT_BIAS);
    end

    // ****************************************
    // stage register
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            s1_sign  <= a.sign ^ b.sign;
            s1_class <= class_ab;
            s1_exp   <= exp_sum;
            s1_sig_a <= {1'b1, a.mant}; // hidden one restored
            s1_sig_b <= {1'b1, b.mant};
        end
    end

endmodule

/* design/float_mant_mul_stage.sv */
`timescale 1ns/10ps
`include "float_mul_settings.svh"

module float_mant_mul_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    s1_valid,
    input  logic                    s1_sign,
    input  float_pkg::float_class_e s1_class,
    input  float_pkg::exp_sum_t     s1_exp,
    input  float_pkg::sig_t         s1_sig_a,
    input  float_pkg::sig_t         s1_sig_b,
    output logic                    s2_valid,
    output logic                    s2_sign,
    output float_pkg::float_class_e s2_class,
    output float_pkg::exp_sum_t     s2_exp,
    output float_pkg::prod_t        s2_prod
);
    import float_pkg::*;

    prod_t prod;

    // ****************************************
    // significand multiply
    // ****************************************

    // both significands carry the hidden one, so the product
    // lies in [2^46, 2^48) and its top bit picks the shift later
    always_comb begin
        prod = prod_t'(s1_sig_a) * prod_t'(s1_sig_b);
    end

    // ****************************************
    // stage register
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_sign  <= s1_sign; // side info rides along
            s2_class <= s1_class;
            s2_exp   <= s1_exp;
            s2_prod  <= prod;
        end
    end

endmodule

/* design/float_normalize_stage.sv */
`timescale 1ns/10ps
`include "float_mul_settings.svh"

module float_normalize_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    s2_valid,
    input  logic                    s2_sign,
    input  float_pkg::float_class_e s2_class,
    input  float_pkg::exp_sum_t     s2_exp,
    input  float_pkg::prod_t        s2_prod,
    output logic                    ack,
    output float_pkg::float_t       out
);
    import float_pkg::*;

    logic                         top_bit;
    logic [`FLOAT_MANT_WIDTH-1:0] mant_norm;
    exp_sum_t                     exp_adj;
    float_class_e                 range_class;
    float_class_e                 res_class;
    float_t                       result;

    // ****************************************
    // normalize
    // ****************************************

    always_comb begin
        top_bit = s2_prod[2*`FLOAT_MANT_WIDTH+1];

        if (top_bit) begin
            // product in [2,4), drop one more bit and bump exponent
            mant_norm = s2_prod[2*`FLOAT_MANT_WIDTH -: `FLOAT_MANT_WIDTH];
            exp_adj   = s2_exp + exp_sum_t'(1);
        end else begin
            mant_norm = s2_prod[2*`FLOAT_MANT_WIDTH-1 -: `FLOAT_MANT_WIDTH];
            exp_adj   = s2_exp;
        end
    end

    // ****************************************
    // range check and packing
    // ****************************************

    always_comb begin
        if (exp_adj <= exp_sum_t'(0)) begin
            range_class = FC_ZERO; // underflow, flush
        end else if (exp_adj >= exp_sum_t'((1 << `FLOAT_EXP_WIDTH) - 1)) begin
            range_class = FC_INF; // 255 and up, saturate
        end else begin
            range_class = FC_NORMAL;
        end

        // special operands override whatever the arithmetic says
        if (s2_class == FC_NORMAL) begin
            res_class = range_class;
        end else begin
            res_class = s2_class;
        end

        result.sign = s2_sign;
        case (res_class)
            FC_ZERO: begin
                result.exp  = '0;
                result.mant = '0;
            end
            FC_INF: begin
                result.exp  = '1;
                result.mant = '0;
            end
            default: begin
                result.exp  = exp_adj[`FLOAT_EXP_WIDTH-1:0];
                result.mant = mant_norm; // truncated, no rounding
            end
        endcase
    end

    // ****************************************
    // output register
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            out <= '0;
        end else begin
            ack <= s2_valid; // one pulse per operation
            if (s2_valid) begin
                out <= result; // held until the next ack
            end
        end
    end

endmodule

/* design/float_mul_pipeline.sv */
`timescale 1ns/10ps
`include "float_mul_settings.svh"

module float_mul_pipeline (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  float_pkg::float_t a,
    input  float_pkg::float_t b,
    output logic              ack,
    output float_pkg::float_t out
);
    import float_pkg::*;

    // stage 1 -> stage 2
    logic         s1_valid;
    logic         s1_sign;
    float_class_e s1_class;
    exp_sum_t     s1_exp;
    sig_t         s1_sig_a;
    sig_t         s1_sig_b;

    // stage 2 -> stage 3
    logic         s2_valid;
    logic         s2_sign;
    float_class_e s2_class;
    exp_sum_t     s2_exp;
    prod_t        s2_prod;

    float_unpack_stage unpack0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .a        (a),
        .b        (b),
        .s1_valid (s1_valid),
        .s1_sign  (s1_sign),
        .s1_class (s1_class),
        .s1_exp   (s1_exp),
        .s1_sig_a (s1_sig_a),
        .s1_sig_b (s1_sig_b)
    );

    float_mant_mul_stage mul0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .s1_valid (s1_valid),
        .s1_sign  (s1_sign),
        .s1_class (s1_class),
        .s1_exp   (s1_exp),
        .s1_sig_a (s1_sig_a),
        .s1_sig_b (s1_sig_b),
        .s2_valid (s2_valid),
        .s2_sign  (s2_sign),
        .s2_class (s2_class),
        .s2_exp   (s2_exp),
        .s2_prod  (s2_prod)
    );

    float_normalize_stage norm0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .s2_valid (s2_valid),
        .s2_sign  (s2_sign),
        .s2_class (s2_class),
        .s2_exp   (s2_exp),
        .s2_prod  (s2_prod),
        .ack      (ack),
        .out      (out)
    );

endmodule

/* tb/float_mul_tb.sv */
`timescale 1ns/10ps
`include "float_mul_settings.svh"

module float_mul_tb;
    import float_pkg::*;

    localparam int LATENCY     = 3;
    localparam int DRAIN_LIMIT = 40;

    localparam float_t F_ZERO  = 32'h0000_0000;
    localparam float_t F_NZERO = 32'h8000_0000;
    localparam float_t F_ONE   = 32'h3f80_0000;
    localparam float_t F_NONE  = 32'hbf80_0000;
    localparam float_t F_TWO   = 32'h4000_0000;
    localparam float_t F_INF   = 32'h7f80_0000;
    localparam float_t F_NINF  = 32'hff80_0000;

    logic   clk;
    logic   rst_n;
    logic   req;
    float_t a;
    float_t b;
    logic   ack;
    float_t out;

    integer seed;
    int     cyc;
    int     errors;
    int     tests_passed;
    int     tests_failed;
    int     req_count;
    int     ack_count;

    float_t exp_q[$];     // expected results in request order
    int     req_cyc_q[$]; // edge at which each req was sampled

    float_mul_pipeline dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .a     (a),
        .b     (b),
        .ack   (ack),
        .out   (out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ****************************************
    // reference model and helpers
    // ****************************************

    function automatic float_t model_mul(input float_t x, input float_t y);
        float_t            r;
        longint unsigned   sx;
        longint unsigned   sy;
        longint unsigned   p;
        int                e;
        logic [22:0]       m;
        r.sign = x.sign ^ y.sign;
        r.exp  = '0;
        r.mant = '0;
        if (x.exp == 8'h00 || y.exp == 8'h00) begin
            r.exp = 8'h00; // zero wins, even against infinity
        end else if (x.exp == 8'hff || y.exp == 8'hff) begin
            r.exp = 8'hff;
        end else begin
            sx = 64'({1'b1, x.mant});
            sy = 64'({1'b1, y.mant});
            p  = sx * sy;
            e  = int'(x.exp) + int'(y.exp) - `FLOAT_BIAS;
            if (p >= (64'd1 << 47)) begin
                m = p[46:24];
                e = e + 1;
            end else begin
                m = p[45:23];
            end
            if (e <= 0) begin
                r.exp = 8'h00; // flush
            end else if (e >= 255) begin
                r.exp = 8'hff; // saturate
            end else begin
                r.exp  = e[7:0];
                r.mant = m;
            end
        end
        return r;
    endfunction

    function automatic real to_real(input float_t f);
        real r;
        if (f.exp == 8'h00) begin
            r = 0.0;
        end else begin
            r = (1.0 + real'(f.mant) / 8388608.0) * (2.0 ** (real'(int'(f.exp)) - 127.0));
        end
        if (f.sign) begin
            r = -r;
        end
        return r;
    endfunction

    function automatic float_t random_operand();
        float_t r;
        int     pick;
        r    = float_t'($random(seed));
        pick = $random(seed) & 7;
        if (pick != 0) begin
            r.exp = 8'(100 + ($random(seed) & 63)); // mostly moderate exponents
        end
        return r;
    endfunction

    // ****************************************
    // compare tasks
    // ****************************************

    task automatic check_float(input float_t got, input float_t expected, input string what);
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s got %h (%g), expected %h (%g)",
                     $time, what, got, to_real(got), expected, to_real(expected));
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s got %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic check_count(input int got, input int expected, input string what);
        if (got != expected) begin
            errors++;
            $display("ERROR at %0t ns: %s got %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_latency(input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("ERROR at %0t ns: ack came %0d cycles after its req, expected %0d",
                     $time, got, expected);
        end
    endtask

    // result monitor, samples away from the rising edge
    always @(negedge clk) begin
        float_t expected;
        int     req_cyc;
        if (ack === 1'b1) begin
            ack_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("an ack arrived at %0t ns with no request pending", $time);
            end else begin
                expected = exp_q.pop_front();
                req_cyc  = req_cyc_q.pop_front();
                check_float(out, expected, "result");
                check_latency(cyc + 1 - req_cyc, LATENCY); // ack seen at the next edge
            end
        end
    end

    // ****************************************
    // drivers
    // ****************************************

    task automatic issue(input float_t x, input float_t y);
        @(posedge clk);
        #1;
        req = 1'b1;
        a   = x;
        b   = y;
        exp_q.push_back(model_mul(x, y));
        req_cyc_q.push_back(cyc + 1); // sampled at the next edge
        req_count++;
    endtask

    // also pins the model to a hand-computed value
    task automatic issue_known(input float_t x, input float_t y, input float_t known,
                               input string what);
        check_float(model_mul(x, y), known, what);
        issue(x, y);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            req = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        idle(1);
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timed out: %0d results still missing after %0d cycles",
                     exp_q.size(), DRAIN_LIMIT);
            exp_q.delete();
            req_cyc_q.delete();
        end
        idle(2); // room for a stray ack to show up
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ****************************************
    // tests
    // ****************************************

    task automatic test_reset();
        int e0;
        e0    = errors;
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_flag(ack, 1'b0, "ack in reset");
            check_float(out, F_ZERO, "out in reset");
        end
        rst_n = 1'b1;
        repeat (6) begin
            idle(1);
            check_flag(ack, 1'b0, "ack after reset");
            check_float(out, F_ZERO, "out after reset");
        end
        report_test("reset", e0);
    endtask

    task automatic test_zero_operands();
        int e0;
        e0 = errors;
        issue_known(F_ZERO, F_ONE, F_ZERO, "model 0*1");
        issue_known(F_ONE, F_ZERO, F_ZERO, "model 1*0");
        issue_known(F_ZERO, F_ZERO, F_ZERO, "model 0*0");
        issue_known(F_ZERO, F_INF, F_ZERO, "model 0*inf");
        issue_known(F_NINF, F_ZERO, F_NZERO, "model -inf*0");
        issue_known(F_NZERO, F_ONE, F_NZERO, "model -0*1");
        issue_known(F_ONE, F_NZERO, F_NZERO, "model 1*-0");
        issue_known(F_NZERO, F_NINF, F_ZERO, "model -0*-inf");
        issue_known(32'h0000_0001, F_TWO, F_ZERO, "model subnormal*2");
        drain();
        report_test("zero_operands", e0);
    endtask

    task automatic test_exact_products();
        int e0;
        e0 = errors;
        issue_known(F_ONE, F_ONE, 32'h3f80_0000, "model 1*1");
        issue_known(F_ONE, F_TWO, 32'h4000_0000, "model 1*2");
        issue_known(F_TWO, F_TWO, 32'h4080_0000, "model 2*2");
        issue_known(32'h4100_0000, 32'h4080_0000, 32'h4200_0000, "model 8*4");
        issue_known(32'h42ca_0000, 32'h4080_0000, 32'h43ca_0000, "model 101*4");
        issue_known(32'h4348_0000, 32'h42c8_0000, 32'h469c_4000, "model 200*100");
        issue_known(F_NONE, F_ONE, F_NONE, "model -1*1");
        // 2000 x 2.3 in every sign combination
        issue(32'h44fa_0000, 32'h4013_3333);
        issue(32'hc4fa_0000, 32'h4013_3333);
        issue(32'h44fa_0000, 32'hc013_3333);
        issue(32'hc4fa_0000, 32'hc013_3333);
        drain();
        report_test("exact_products", e0);
    endtask

    task automatic test_range_limits();
        int e0;
        e0 = errors;
        issue_known(32'h7e00_0000, 32'h7e00_0000, F_INF, "model big*big");
        issue_known(32'h7e00_0000, 32'hfe00_0000, F_NINF, "model big*-big");
        issue_known(32'h7f00_0000, F_TWO, F_INF, "model 2^127*2");
        issue_known(32'h0100_0000, 32'h0100_0000, F_ZERO, "model small*small");
        issue_known(32'h8100_0000, 32'h0100_0000, F_NZERO, "model -small*small");
        issue_known(32'h0080_0000, F_ONE, 32'h0080_0000, "model min normal*1");
        issue_known(32'h0080_0000, 32'h3f00_0000, F_ZERO, "model min normal*0.5");
        issue_known(F_INF, F_TWO, F_INF, "model inf*2");
        issue_known(F_TWO, F_NINF, F_NINF, "model 2*-inf");
        issue_known(32'h7fc0_0000, F_ONE, F_INF, "model nan code*1");
        drain();
        report_test("range_limits", e0);
    endtask

    task automatic test_throughput();
        int     e0;
        int     acks0;
        int     reqs0;
        float_t x;
        float_t y;
        e0    = errors;
        acks0 = ack_count;
        reqs0 = req_count;
        repeat (16) begin
            x = random_operand();
            y = random_operand();
            issue(x, y); // back to back, req never drops
        end
        drain();
        check_count(ack_count - acks0, req_count - reqs0, "acks vs requests");
        report_test("throughput", e0);
    endtask

    task automatic test_random_mix();
        int     e0;
        int     acks0;
        int     reqs0;
        int     gap;
        float_t x;
        float_t y;
        e0    = errors;
        acks0 = ack_count;
        reqs0 = req_count;
        repeat (200) begin
            x   = random_operand();
            y   = random_operand();
            gap = $unsigned($random(seed)) % 4;
            issue(x, y);
            idle(gap);
        end
        drain();
        check_count(ack_count - acks0, req_count - reqs0, "acks vs requests");
        report_test("random_mix", e0);
    endtask

    // ****************************************
    // main sequence
    // ****************************************

    initial begin
        seed         = 32'h3079_1c04;
        rst_n        = 1'b0;
        req          = 1'b0;
        a            = '0;
        b            = '0;
        cyc          = 0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        req_count    = 0;
        ack_count    = 0;

        test_reset();
        test_zero_operands();
        test_exact_products();
        test_range_limits();
        test_throughput();
        test_random_mix();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+common
common/float_pkg.sv
design/float_unpack_stage.sv
design/float_mant_mul_stage.sv
design/float_normalize_stage.sv
design/float_mul_pipeline.sv
tb/float_mul_tb.sv

/* Bender.yml */
package:
  name: float_mul

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/float_pkg.sv
      - design/float_unpack_stage.sv
      - design/float_mant_mul_stage.sv
      - design/float_normalize_stage.sv
      - design/float_mul_pipeline.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - tb/float_mul_tb.sv
